// ==== spiTxSubsystem.f ====
design/spiMasterPkg.sv
design/txFifoBusIf.sv
design/asyncTxFifo.sv
design/spiByteSender.sv
design/spiTxSubsystem.sv
bench/spiTxSubsystemTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module spiTxSubsystemTb \
  -f spiTxSubsystem.f -o spiTxSubsystemSim

simOutput="$(./obj_dir/spiTxSubsystemSim)"
echo "$simOutput"

if grep -q "Verification passed" <<< "$simOutput"; then
  exit 0
else
  exit 1
fi

// ==== bench/spiTxSubsystemTb.sv ====
`timescale 1ns/1ns

module spiTxSubsystemTb;
  import spiMasterPkg::*;

  logic busClk;
  logic spiSysClk;
  logic rstSyncToBusClk;
  logic [2:0] address;
  logic writeEn;
  logic strobe_i;
  logic fifoSelect;
  logic [busDataWidth-1:0] busDataIn;
  logic [busDataWidth-1:0] busDataOut;
  logic sclk;
  logic mosi;
  logic spiCsN;

  // bytes written by the host and bytes seen on mosi, in order
  logic [busDataWidth-1:0] sentQ[$];
  logic [busDataWidth-1:0] recvQ[$];
  logic [busDataWidth-1:0] shiftIn = '0;
  int bitsIn = 0;
  int sclkEdges = 0;
  int checkCount = 0;
  int errorCount = 0;
  int timeoutCount = 0;

  spiTxSubsystem i_spiTxSubsystem (.*);

  // busClk runs the host side of the DUT
  initial begin
    busClk = 1'b0;
    forever #50 busClk = ~busClk;
  end

  // spiSysClk is unrelated to busClk and only lines up with it now and then
  initial begin
    spiSysClk = 1'b0;
    forever #35 spiSysClk = ~spiSysClk;
  end

  // mosi is steady on the rising sclk edge, frames are whole bytes MSB first
  always @(posedge sclk) begin
    shiftIn = {shiftIn[busDataWidth-2:0], mosi};
    bitsIn++;
    sclkEdges++;
    if (bitsIn == busDataWidth) begin
      recvQ.push_back(shiftIn);
      bitsIn = 0;
    end
  end

  ////////////////////////////////////////////////////////////
  // bus access and compare helpers
  ////////////////////////////////////////////////////////////

  task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                            input string msg);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  // one strobe cycle, then the bus goes idle again
  task automatic busWrite(input logic [2:0] addr, input logic [busDataWidth-1:0] data);
    @(posedge busClk);
    address <= addr;
    writeEn <= 1'b1;
    strobe_i <= 1'b1;
    fifoSelect <= 1'b1;
    busDataIn <= data;
    @(posedge busClk);
    writeEn <= 1'b0;
    strobe_i <= 1'b0;
    fifoSelect <= 1'b0;
  endtask

  // busDataOut is a mux of address, so it is taken at the falling edge
  task automatic busRead(input logic [2:0] addr, output logic [busDataWidth-1:0] data);
    @(posedge busClk);
    address <= addr;
    writeEn <= 1'b0;
    strobe_i <= 1'b1;
    fifoSelect <= 1'b1;
    @(negedge busClk);
    data = busDataOut;
    @(posedge busClk);
    strobe_i <= 1'b0;
    fifoSelect <= 1'b0;
  endtask

  task automatic readCount(output logic [15:0] count);
    logic [busDataWidth-1:0] low;
    logic [busDataWidth-1:0] high;
    busRead(fifoCountLowReg, low);
    busRead(fifoCountHighReg, high);
    count = {high, low};
  endtask

  // the count lags the read side, so it must read the same 8 times in a row
  task automatic waitCountStable(output logic [15:0] count);
    logic [15:0] last;
    int same;
    int tries;
    same = 0;
    tries = 0;
    readCount(last);
    count = last;
    while (same < 8 && tries < 300) begin
      readCount(count);
      if (count == last) same++;
      else same = 0;
      last = count;
      tries++;
    end
    if (same < 8) begin
      timeoutCount++;
      $display("Timeout at %0t ns: the FIFO count never settled", $time);
    end
  endtask

  task automatic waitCountValue(input logic [15:0] expected, input string msg);
    logic [15:0] count;
    int tries;
    tries = 0;
    readCount(count);
    while (count != expected && tries < 500) begin
      readCount(count);
      tries++;
    end
    if (count != expected) begin
      timeoutCount++;
      $display("Timeout at %0t ns: the FIFO count never reached %0d", $time, expected);
    end
    checkValue(count, expected, msg);
  endtask

  task automatic waitReceived(input int n);
    int cycles;
    cycles = 0;
    while (recvQ.size() < n && cycles < 3000) begin
      @(posedge busClk);
      cycles++;
    end
    if (recvQ.size() < n) begin
      timeoutCount++;
      $display("Timeout at %0t ns: only %0d of %0d bytes came out on mosi", $time,
               recvQ.size(), n);
    end
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    while (spiCsN !== 1'b1 && cycles < 500) begin
      @(posedge busClk);
      cycles++;
    end
    if (spiCsN !== 1'b1) begin
      timeoutCount++;
      $display("Timeout at %0t ns: spiCsN stayed low", $time);
    end
  endtask

  // the received bytes must be exactly the first n bytes that were sent
  task automatic compareQueues(input int n, input string msg);
    checkValue(recvQ.size(), n, {msg, " byte count"});
    for (int i = 0; i < n && i < recvQ.size(); i++) begin
      checkValue(recvQ[i], sentQ[i], msg);
    end
  endtask

  task automatic writeRandomBytes(input int n);
    logic [busDataWidth-1:0] b;
    repeat (n) begin
      b = busDataWidth'($urandom);
      sentQ.push_back(b);
      busWrite(fifoDataReg, b);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////

  task automatic resetValues();
    logic [busDataWidth-1:0] data;
    logic [15:0] count;
    checkValue(spiCsN, 1'b1, "spiCsN after reset");
    checkValue(sclk, 1'b0, "sclk after reset");
    busRead(fifoControlReg, data);
    checkValue(data, 8'h00, "control register after reset");
    readCount(count);
    checkValue(count, 16'h0000, "count after reset");
  endtask

  task automatic enabledStream();
    sentQ.delete();
    recvQ.delete();
    busWrite(fifoControlReg, 8'h02);
    writeRandomBytes(20);
    waitReceived(20);
    waitIdle();
    compareQueues(20, "enabled stream");
  endtask

  // nothing may move on the pins while txEnable is clear
  task automatic heldTransmit();
    logic [15:0] count;
    int edgesBefore;
    sentQ.delete();
    recvQ.delete();
    busWrite(fifoControlReg, 8'h00);
    edgesBefore = sclkEdges;
    writeRandomBytes(10);
    waitCountStable(count);
    checkValue(count[7:0], 8'd10, "held count low byte");
    checkValue(count[15:8], 8'd0, "held count high byte");
    checkValue(sclkEdges, edgesBefore, "sclk edges while held");
    busWrite(fifoControlReg, 8'h02);
    waitReceived(10);
    waitIdle();
    compareQueues(10, "released bytes");
    waitCountValue(16'd0, "count after release");
  endtask

  task automatic forceEmpty();
    logic [busDataWidth-1:0] data;
    recvQ.delete();
    busWrite(fifoControlReg, 8'h00);
    writeRandomBytes(5);
    busWrite(fifoControlReg, 8'h01);
    waitCountValue(16'd0, "count after force-empty");
    // bit 0 is write-only, so only txEnable reads back
    busRead(fifoControlReg, data);
    checkValue(data, 8'h00, "control after force-empty");
    sentQ.delete();
    busWrite(fifoControlReg, 8'h02);
    busRead(fifoControlReg, data);
    checkValue(data, 8'h02, "control with txEnable set");
    writeRandomBytes(1);
    waitReceived(1);
    waitIdle();
    repeat (40) @(posedge busClk);
    compareQueues(1, "byte after force-empty");
  endtask

  // writes past fifoDepth are lost without any stall
  task automatic overflow();
    logic [15:0] count;
    sentQ.delete();
    recvQ.delete();
    busWrite(fifoControlReg, 8'h00);
    writeRandomBytes(70);
    waitCountStable(count);
    checkValue(count, 16'(fifoDepth), "count when full");
    busWrite(fifoControlReg, 8'h02);
    waitReceived(fifoDepth);
    waitIdle();
    repeat (40) @(posedge busClk);
    compareQueues(fifoDepth, "bytes after overflow");
    waitCountValue(16'd0, "count after overflow drain");
  endtask

  initial begin
    void'($urandom(64036));
    rstSyncToBusClk = 1'b1;
    address = '0;
    writeEn = 1'b0;
    strobe_i = 1'b0;
    fifoSelect = 1'b0;
    busDataIn = '0;
    repeat (16) @(posedge busClk);
    rstSyncToBusClk <= 1'b0;
    repeat (4) @(posedge busClk);

    resetValues();
    enabledStream();
    heldTransmit();
    forceEmpty();
    overflow();

    $display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== design/spiTxSubsystem.sv ====
`timescale 1ns/1ns

module spiTxSubsystem (
  input  logic busClk,
  input  logic spiSysClk,
  input  logic rstSyncToBusClk,
  input  logic [2:0] address,
  input  logic writeEn,
  input  logic strobe_i,
  input  logic fifoSelect,
  input  logic [spiMasterPkg::busDataWidth-1:0] busDataIn,
  output logic [spiMasterPkg::busDataWidth-1:0] busDataOut,
  output logic sclk,
  output logic mosi,
  output logic spiCsN
);
  import spiMasterPkg::*;

  ////////////////////////////////////////////////////////////
  // wires between the three blocks
  ////////////////////////////////////////////////////////////

  logic fifoWEn;
  logic fifoREn;
  logic fifoEmpty;
  logic txEnable;
  logic forceEmptySyncToBusClk;
  logic forceEmptySyncToSpiClk;
  logic [countWidth-1:0] numElementsInFifo;
  logic [busDataWidth-1:0] readData;

  // host registers, force-empty crossing and read mux
  txFifoBusIf i_txFifoBusIf (.*);

  // bytes cross from busClk into spiSysClk here
  asyncTxFifo i_asyncTxFifo (.*);

  // drains the FIFO onto the SPI pins
  spiByteSender i_spiByteSender (
    .spiSysClk(spiSysClk),
    .rstSyncToBusClk(rstSyncToBusClk),
    .txEnable(txEnable),
    .fifoEmpty(fifoEmpty),
    .readData(readData),
    .fifoREn(fifoREn),
    .sclk(sclk),
    .mosi(mosi),
    .spiCsN(spiCsN)
  );

endmodule

// ==== design/spiByteSender.sv ====
`timescale 1ns/1ns

module spiByteSender (
  input  logic spiSysClk,
  input  logic rstSyncToBusClk,
  input  logic txEnable,
  input  logic fifoEmpty,
  input  logic [spiMasterPkg::busDataWidth-1:0] readData,
  output logic fifoREn,
  output logic sclk,
  output logic mosi,
  output logic spiCsN
);
  import spiMasterPkg::*;

  logic rstMeta;
  logic rstSyncToSpiClk;
  logic txEnableMeta;
  logic txEnableSync;
  logic shifting;
  logic lastBitDone;
  logic [2:0] bitCount;
  logic [busDataWidth-1:0] shiftReg;

  // reset comes from the bus domain, so it is synchronised here first
  always_ff @(posedge spiSysClk) begin
    rstMeta <= rstSyncToBusClk;
    rstSyncToSpiClk <= rstMeta;
  end

  // txEnable is seen two spiSysClk cycles after the host changes it
  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClk) begin
      txEnableMeta <= 1'b0;
      txEnableSync <= 1'b0;
    end else begin
      txEnableMeta <= txEnable;
      txEnableSync <= txEnableMeta;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame control and serialiser
  ////////////////////////////////////////////////////////////

  // the last bit ends on the edge that brings sclk back low
  assign lastBitDone = shifting && sclk && (bitCount == 3'(busDataWidth - 1));

  // pop when idle, or at the end of a byte so that the next one follows back to back
  assign fifoREn = (!shifting || lastBitDone) && txEnableSync && !fifoEmpty;

  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClk) begin
      shifting <= 1'b0;
      spiCsN <= 1'b1;
      sclk <= 1'b0;
      mosi <= 1'b0;
      bitCount <= '0;
      shiftReg <= '0;
    end else if (fifoREn) begin
      // load the head byte, first bit goes out while sclk is still low
      shifting <= 1'b1;
      spiCsN <= 1'b0;
      sclk <= 1'b0;
      mosi <= readData[busDataWidth-1];
      shiftReg <= readData << 1;
      bitCount <= '0;
    end else if (shifting) begin
      sclk <= ~sclk;
      if (lastBitDone) begin
        // nothing to send, spiCsN rises on the next cycle
        shifting <= 1'b0;
        mosi <= 1'b0;
      end else if (sclk) begin
        mosi <= shiftReg[busDataWidth-1];
        shiftReg <= shiftReg << 1;
        bitCount <= bitCount + 1'b1;
      end
    end else begin
      spiCsN <= 1'b1;
    end
  end

endmodule

// ==== design/asyncTxFifo.sv ====
`timescale 1ns/1ns

module asyncTxFifo (
  input  logic busClk,
  input  logic spiSysClk,
  input  logic rstSyncToBusClk,
  input  logic fifoWEn,
  input  logic [spiMasterPkg::busDataWidth-1:0] busDataIn,
  input  logic forceEmptySyncToBusClk,
  input  logic forceEmptySyncToSpiClk,
  input  logic fifoREn,
  output logic [spiMasterPkg::countWidth-1:0] numElementsInFifo,
  output logic fifoEmpty,
  output logic [spiMasterPkg::busDataWidth-1:0] readData
);
  import spiMasterPkg::*;

  // pointers carry one extra bit to tell full from empty
  logic [busDataWidth-1:0] mem [fifoDepth];

  logic [fifoAddrWidth:0] wrPtrBin;
  logic [fifoAddrWidth:0] wrPtrNext;
  logic [fifoAddrWidth:0] wrPtrGray;
  logic [fifoAddrWidth:0] rdPtrGrayMeta;
  logic [fifoAddrWidth:0] rdPtrGraySyncBus;
  logic [fifoAddrWidth:0] rdPtrBinSyncBus;
  logic [fifoAddrWidth:0] fillLevel;
  logic fifoFull;
  logic pushEn;

  logic rstMeta;
  logic rstSyncToSpiClk;
  logic [fifoAddrWidth:0] rdPtrBin;
  logic [fifoAddrWidth:0] rdPtrNext;
  logic [fifoAddrWidth:0] rdPtrGray;
  logic [fifoAddrWidth:0] wrPtrGrayMeta;
  logic [fifoAddrWidth:0] wrPtrGraySyncSpi;

  function automatic logic [fifoAddrWidth:0] binToGray(input logic [fifoAddrWidth:0] bin);
    return bin ^ (bin >> 1);
  endfunction

  // each binary bit is the XOR of all Gray bits at and above it
  function automatic logic [fifoAddrWidth:0] grayToBin(input logic [fifoAddrWidth:0] gray);
    logic [fifoAddrWidth:0] bin;
    bin[fifoAddrWidth] = gray[fifoAddrWidth];
    for (int i = fifoAddrWidth - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  ////////////////////////////////////////////////////////////
  // write side in busClk
  ////////////////////////////////////////////////////////////

  // the read pointer arrives through two flops as Gray code
  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      rdPtrGrayMeta <= '0;
      rdPtrGraySyncBus <= '0;
    end else begin
      rdPtrGrayMeta <= rdPtrGray;
      rdPtrGraySyncBus <= rdPtrGrayMeta;
    end
  end

  assign rdPtrBinSyncBus = grayToBin(rdPtrGraySyncBus);
  assign fillLevel = wrPtrBin - rdPtrBinSyncBus;

  // the fill level never passes fifoDepth, so its top bit means full
  assign fifoFull = fillLevel[fifoAddrWidth];
  assign numElementsInFifo = {{(countWidth-fifoAddrWidth-1){1'b0}}, fillLevel};

  // a write to a full FIFO is dropped, and so is one that meets a force-empty
  assign pushEn = fifoWEn & ~fifoFull & ~forceEmptySyncToBusClk;

  always_comb begin
    wrPtrNext = wrPtrBin;
    if (forceEmptySyncToBusClk) begin
      wrPtrNext = rdPtrBinSyncBus;
    end else if (pushEn) begin
      wrPtrNext = wrPtrBin + 1'b1;
    end
  end

  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      wrPtrBin <= '0;
      wrPtrGray <= '0;
    end else begin
      wrPtrBin <= wrPtrNext;
      wrPtrGray <= binToGray(wrPtrNext);
    end
  end

  always_ff @(posedge busClk) begin
    if (pushEn) begin
      mem[wrPtrBin[fifoAddrWidth-1:0]] <= busDataIn;
    end
  end

  ////////////////////////////////////////////////////////////
  // read side in spiSysClk
  ////////////////////////////////////////////////////////////

  // bring reset into this domain before it touches the read pointer
  always_ff @(posedge spiSysClk) begin
    rstMeta <= rstSyncToBusClk;
    rstSyncToSpiClk <= rstMeta;
  end

  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClk) begin
      wrPtrGrayMeta <= '0;
      wrPtrGraySyncSpi <= '0;
    end else begin
      wrPtrGrayMeta <= wrPtrGray;
      wrPtrGraySyncSpi <= wrPtrGrayMeta;
    end
  end

  // equal Gray pointers mean nothing is left to read
  assign fifoEmpty = (rdPtrGray == wrPtrGraySyncSpi);
  assign readData = mem[rdPtrBin[fifoAddrWidth-1:0]];

  always_comb begin
    rdPtrNext = rdPtrBin;
    if (forceEmptySyncToSpiClk) begin
      rdPtrNext = grayToBin(wrPtrGraySyncSpi);
    end else if (fifoREn && !fifoEmpty) begin
      rdPtrNext = rdPtrBin + 1'b1;
    end
  end

  always_ff @(posedge spiSysClk) begin
    if (rstSyncToSpiClk) begin
      rdPtrBin <= '0;
      rdPtrGray <= '0;
    end else begin
      rdPtrBin <= rdPtrNext;
      rdPtrGray <= binToGray(rdPtrNext);
    end
  end

endmodule

// ==== design/txFifoBusIf.sv ====
`timescale 1ns/1ns

module txFifoBusIf (
  input  logic busClk,
  input  logic spiSysClk,
  input  logic rstSyncToBusClk,
  input  logic [2:0] address,
  input  logic writeEn,
  input  logic strobe_i,
  input  logic fifoSelect,
  input  logic [spiMasterPkg::busDataWidth-1:0] busDataIn,
  input  logic [spiMasterPkg::countWidth-1:0] numElementsInFifo,
  output logic [spiMasterPkg::busDataWidth-1:0] busDataOut,
  output logic fifoWEn,
  output logic forceEmptySyncToBusClk,
  output logic forceEmptySyncToSpiClk,
  output logic txEnable
);
  import spiMasterPkg::*;

  logic busWrite;
  logic controlWrite;
  logic forceEmpty;
  logic forceEmptyReg;
  logic forceEmptyToggle;
  logic [2:0] forceEmptyToggleSync;

  ////////////////////////////////////////////////////////////
  // write decode
  ////////////////////////////////////////////////////////////

  // a transfer is one busClk cycle with strobe_i and fifoSelect both high
  assign busWrite = strobe_i & fifoSelect & writeEn;
  assign controlWrite = busWrite && (address == fifoControlReg);

  // the FIFO write strobe is combinational so the byte lands on this edge
  assign fifoWEn = busWrite && (address == fifoDataReg);

  // txEnable follows bit 1 of every control write while bit 0 only raises a request
  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      txEnable <= 1'b0;
      forceEmpty <= 1'b0;
    end else begin
      forceEmpty <= controlWrite & busDataIn[0];
      if (controlWrite) begin
        txEnable <= busDataIn[1];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // force-empty pulses for both clock domains
  ////////////////////////////////////////////////////////////

  // the rising edge of the request gives the bus pulse and flips the toggle
  always_ff @(posedge busClk) begin
    if (rstSyncToBusClk) begin
      forceEmptyReg <= 1'b0;
      forceEmptyToggle <= 1'b0;
    end else begin
      forceEmptyReg <= forceEmpty;
      if (forceEmpty && !forceEmptyReg) begin
        forceEmptyToggle <= ~forceEmptyToggle;
      end
    end
  end

  assign forceEmptySyncToBusClk = forceEmpty & ~forceEmptyReg;

  // two flops resolve metastability, the third one finds the change
  always_ff @(posedge spiSysClk) begin
    forceEmptyToggleSync <= {forceEmptyToggleSync[1:0], forceEmptyToggle};
  end

  assign forceEmptySyncToSpiClk = forceEmptyToggleSync[2] ^ forceEmptyToggleSync[1];

  // the read mux returns the control byte and both halves of the count
  always_comb begin
    case (address)
      fifoControlReg: busDataOut = {{(busDataWidth-2){1'b0}}, txEnable, 1'b0};
      fifoCountLowReg: busDataOut = numElementsInFifo[busDataWidth-1:0];
      fifoCountHighReg: busDataOut = numElementsInFifo[2*busDataWidth-1:busDataWidth];
      default: busDataOut = '0;
    endcase
  end

endmodule

// ==== design/spiMasterPkg.sv ====
package spiMasterPkg;

  ////////////////////////////////////////////////////////////
  // bus register map
  ////////////////////////////////////////////////////////////

  // a write here pushes one byte into the transmit FIFO
  localparam logic [2:0] fifoDataReg = 3'd0;

  // bit 0 requests a force-empty and always reads back as 0
  // bit 1 is txEnable, which lets the host hold transmission
  localparam logic [2:0] fifoControlReg = 3'd1;

  // the fill count is split into two readable bytes
  localparam logic [2:0] fifoCountLowReg = 3'd2;
  localparam logic [2:0] fifoCountHighReg = 3'd3;

  ////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////

  // one bus byte is also one FIFO entry and one SPI frame
  localparam int busDataWidth = 8;

  // the FIFO address width sets the depth
  localparam int fifoAddrWidth = 6;
  localparam int fifoDepth = 1 << fifoAddrWidth;

  // numElementsInFifo is wider than needed so that it reads as two bytes
  localparam int countWidth = 16;

endpackage
